// File: compile.f
common/fifo_cfg_pkg.sv
common/fifo_types_pkg.sv
fifo/fifo_mem.sv
fifo/fifo_ptr.sv
fifo/fifo.sv
logic/fifo_guard.sv
logic/stream_buffer.sv
testbench/tb_stream_buffer.sv

// File: run_sim.sh
#!/bin/sh
# build the stream_buffer testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_stream_buffer -f compile.f -o tb_stream_buffer \
  && ./obj_dir/tb_stream_buffer > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
echo "run finished without failure"
exit 0

// File: testbench/tb_stream_buffer.sv
`default_nettype none

module tb_stream_buffer;

  localparam int RAND_CYCLES = 400;
  localparam int ERR_MAX     = (1 << fifo_cfg_pkg::ERR_CNT_W) - 1;
  localparam int SAT_CYCLES  = fifo_cfg_pkg::DEPTH + ERR_MAX + 2;
  localparam int TEST_CYCLES = 2 + 2 + 18 + 23 + 22 + (RAND_CYCLES + 2) + (2 * SAT_CYCLES + 2);
  localparam int CYCLE_LIMIT = TEST_CYCLES + 64;                // margin for settling.

  logic                             clk_i;
  logic                             srst_i;
  logic                             wr_req;
  logic [fifo_cfg_pkg::DATA_W-1:0]  wr_data;
  logic                             rd_req;
  logic [fifo_cfg_pkg::DATA_W-1:0]  rd_data;
  fifo_types_pkg::fifo_status_t     status;
  fifo_types_pkg::fifo_err_t        err;

  logic [fifo_cfg_pkg::DATA_W-1:0]  model_q [$];
  int                               model_ovf;
  int                               model_unf;
  logic                             model_live;
  logic [15:0]                      lfsr_r;
  int                               error_cnt;
  int                               check_cnt;
  int                               test_cnt;
  int                               cycle_cnt;
  int                               errs_before;

  stream_buffer u_dut (
    .clk_i     ( clk_i   ),
    .srst_i    ( srst_i  ),
    .wr_req_i  ( wr_req  ),
    .wr_data_i ( wr_data ),
    .rd_req_i  ( rd_req  ),
    .rd_data_o ( rd_data ),
    .status_o  ( status  ),
    .err_o     ( err     )
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ========================================
  // random bits and reference model
  // ========================================

  function automatic logic lfsr_bit();
    logic lsb;
    lsb    = lfsr_r[0];
    lfsr_r = lfsr_r >> 1;
    if (lsb)
    begin
      lfsr_r = lfsr_r ^ 16'hB400;   // galois taps 16,14,13,11.
    end
    return lsb;
  endfunction

  function automatic logic [fifo_cfg_pkg::DATA_W-1:0] lfsr_word();
    logic [fifo_cfg_pkg::DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < fifo_cfg_pkg::DATA_W; i++)
    begin
      v = {v[fifo_cfg_pkg::DATA_W-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  // one clock edge of the buffer, guard rules first.
  function automatic void model_step(logic srst, logic wr, logic rd,
                                     logic [fifo_cfg_pkg::DATA_W-1:0] data);
    logic full_now;
    logic empty_now;
    full_now  = (model_q.size() == fifo_cfg_pkg::DEPTH);
    empty_now = (model_q.size() == 0);
    if (srst)
    begin
      model_q.delete();
      model_ovf = 0;
      model_unf = 0;
    end
    else
    begin
      if (wr && full_now && model_ovf < ERR_MAX)
        model_ovf++;
      if (rd && empty_now && model_unf < ERR_MAX)
        model_unf++;
      if (rd && !empty_now)
        void'(model_q.pop_front());
      if (wr && !full_now)
        model_q.push_back(data);   // data at full is lost.
    end
  endfunction

  function automatic fifo_types_pkg::fifo_status_t expected_status();
    fifo_types_pkg::fifo_status_t s;
    int n;
    n              = model_q.size();
    s.usedw        = fifo_cfg_pkg::CNT_W'(n);
    s.empty        = (n == 0);
    s.full         = (n == fifo_cfg_pkg::DEPTH);
    s.almost_full  = (n >= fifo_cfg_pkg::ALMOST_FULL_LVL);
    s.almost_empty = (n <= fifo_cfg_pkg::ALMOST_EMPTY_LVL);
    return s;
  endfunction

  function automatic fifo_types_pkg::fifo_err_t expected_err();
    fifo_types_pkg::fifo_err_t e;
    e.ovf_cnt = fifo_cfg_pkg::ERR_CNT_W'(model_ovf);
    e.unf_cnt = fifo_cfg_pkg::ERR_CNT_W'(model_unf);
    return e;
  endfunction

  function automatic logic [fifo_cfg_pkg::DATA_W-1:0] expected_word();
    if (model_q.size() == 0)
      return '0;
    return model_q[0];
  endfunction

  // ========================================
  // compare tasks
  // ========================================

  task automatic check_word(string name, logic [fifo_cfg_pkg::DATA_W-1:0] got,
                            logic [fifo_cfg_pkg::DATA_W-1:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      error_cnt++;
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_status(string name, fifo_types_pkg::fifo_status_t got,
                              fifo_types_pkg::fifo_status_t exp);
    check_cnt++;
    if (got !== exp)
    begin
      error_cnt++;
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_err(string name, fifo_types_pkg::fifo_err_t got,
                           fifo_types_pkg::fifo_err_t exp);
    check_cnt++;
    if (got !== exp)
    begin
      error_cnt++;
      $display("** Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  // model sees the same inputs the DUT samples.
  always @(posedge clk_i)
  begin
    model_step(srst_i, wr_req, rd_req, wr_data);
    if (srst_i)
      model_live = 1'b1;
  end

  always @(negedge clk_i)
  begin
    if (model_live)
    begin
      check_word("rd_data_o", rd_data, expected_word());
      check_status("status_o", status, expected_status());
      check_err("err_o", err, expected_err());
    end
  end

  // ========================================
  // stimulus
  // ========================================

  task automatic drive(logic wr, logic rd, logic [fifo_cfg_pkg::DATA_W-1:0] data);
    @(posedge clk_i);
    wr_req  <= wr;
    rd_req  <= rd;
    wr_data <= data;
  endtask

  task automatic end_test(string name);
    drive(1'b0, 1'b0, '0);
    drive(1'b0, 1'b0, '0);   // last request checked by now.
    test_cnt++;
    $display("test %s done, %0d mismatches", name, error_cnt - errs_before);
    errs_before = error_cnt;
  endtask

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    srst_i      = 1'b1;
    wr_req      = 1'b0;
    rd_req      = 1'b0;
    wr_data     = '0;
    model_live  = 1'b0;
    model_ovf   = 0;
    model_unf   = 0;
    lfsr_r      = 16'd90;
    error_cnt   = 0;
    check_cnt   = 0;
    test_cnt    = 0;
    errs_before = 0;
    repeat (2) @(posedge clk_i);
    srst_i <= 1'b0;

    end_test("reset");

    for (int i = 0; i < 8; i++)
      drive(1'b1, 1'b0, fifo_cfg_pkg::DATA_W'(8'h10 + i));
    for (int i = 0; i < 8; i++)
      drive(1'b0, 1'b1, '0);
    end_test("fill_drain");

    for (int i = 0; i < 8; i++)
      drive(1'b1, 1'b0, fifo_cfg_pkg::DATA_W'(8'h20 + i));
    for (int i = 0; i < 3; i++)
      drive(1'b1, 1'b0, fifo_cfg_pkg::DATA_W'(8'hE0 + i));   // dropped at full.
    for (int i = 0; i < 10; i++)
      drive(1'b0, 1'b1, '0);                                 // last two underflow.
    end_test("overflow");

    for (int i = 0; i < 4; i++)
      drive(1'b1, 1'b0, fifo_cfg_pkg::DATA_W'(8'h40 + i));
    for (int i = 0; i < 4; i++)
      drive(1'b1, 1'b1, fifo_cfg_pkg::DATA_W'(8'h50 + i));
    for (int i = 0; i < 4; i++)
      drive(1'b1, 1'b0, fifo_cfg_pkg::DATA_W'(8'h60 + i));
    drive(1'b1, 1'b1, 8'h7F);                                // write lost, read taken.
    for (int i = 0; i < 7; i++)
      drive(1'b0, 1'b1, '0);
    end_test("simultaneous");

    for (int i = 0; i < RAND_CYCLES; i++)
      drive(lfsr_bit(), lfsr_bit(), lfsr_word());
    end_test("random");

    for (int i = 0; i < SAT_CYCLES; i++)
      drive(1'b1, 1'b0, lfsr_word());                        // ovf_cnt pins at all ones.
    for (int i = 0; i < SAT_CYCLES; i++)
      drive(1'b0, 1'b1, '0);                                 // unf_cnt pins at all ones.
    end_test("saturate");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
    if (error_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule : tb_stream_buffer

`default_nettype wire

// File: logic/stream_buffer.sv
`default_nettype none

module stream_buffer (
  input  logic                              clk_i,
  input  logic                              srst_i,

  input  logic                              wr_req_i,
  input  logic [fifo_cfg_pkg::DATA_W-1:0]   wr_data_i,
  input  logic                              rd_req_i,

  output logic [fifo_cfg_pkg::DATA_W-1:0]   rd_data_o,
  output fifo_types_pkg::fifo_status_t      status_o,
  output fifo_types_pkg::fifo_err_t         err_o
);

  logic                          wr_en;
  logic                          rd_en;
  fifo_types_pkg::fifo_status_t  status;

  // ======================================
  // request guard
  // ======================================

  fifo_guard u_guard (
    .clk_i     ( clk_i    ),
    .srst_i    ( srst_i   ),

    .wr_req_i  ( wr_req_i ),
    .rd_req_i  ( rd_req_i ),
    .status_i  ( status   ),

    .wr_en_o   ( wr_en    ),
    .rd_en_o   ( rd_en    ),
    .err_o     ( err_o    )
  );

  // ======================================
  // fifo core
  // ======================================

  fifo u_fifo (
    .clk_i     ( clk_i     ),
    .srst_i    ( srst_i    ),

    .wr_en_i   ( wr_en     ),
    .rd_en_i   ( rd_en     ),
    .wr_data_i ( wr_data_i ),

    .rd_data_o ( rd_data_o ),
    .status_o  ( status    )
  );

  assign status_o = status;   // guard and outside see the same word.

endmodule : stream_buffer

`default_nettype wire

// File: logic/fifo_guard.sv
`default_nettype none

module fifo_guard (
  input  logic                              clk_i,
  input  logic                              srst_i,

  input  logic                              wr_req_i,
  input  logic                              rd_req_i,
  input  fifo_types_pkg::fifo_status_t      status_i,

  output logic                              wr_en_o,
  output logic                              rd_en_o,
  output fifo_types_pkg::fifo_err_t         err_o
);

  logic                       wr_reject;
  logic                       rd_reject;
  fifo_types_pkg::fifo_err_t  err_r;

  // ======================================
  // request gating
  // ======================================

  // a write at full is dropped even with a read in the same cycle.
  assign wr_en_o   = wr_req_i & ~status_i.full;
  assign rd_en_o   = rd_req_i & ~status_i.empty;

  assign wr_reject = wr_req_i & status_i.full;    // overflow attempt.
  assign rd_reject = rd_req_i & status_i.empty;   // underflow attempt.

  // ======================================
  // rejection counters
  // ======================================

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      err_r.ovf_cnt <= '0;
    end
    else if (wr_reject && (err_r.ovf_cnt != '1))
    begin
      err_r.ovf_cnt <= err_r.ovf_cnt + 1'b1;   // holds at all ones.
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      err_r.unf_cnt <= '0;
    end
    else if (rd_reject && (err_r.unf_cnt != '1))
    begin
      err_r.unf_cnt <= err_r.unf_cnt + 1'b1;   // holds at all ones.
    end
  end

  assign err_o = err_r;

endmodule : fifo_guard

`default_nettype wire

// File: fifo/fifo.sv
`default_nettype none

module fifo (
  input  logic                              clk_i,
  input  logic                              srst_i,

  input  logic                              wr_en_i,
  input  logic                              rd_en_i,
  input  logic [fifo_cfg_pkg::DATA_W-1:0]   wr_data_i,

  output logic [fifo_cfg_pkg::DATA_W-1:0]   rd_data_o,
  output fifo_types_pkg::fifo_status_t      status_o
);

  logic [fifo_cfg_pkg::ADDR_W-1:0] wr_addr;
  logic [fifo_cfg_pkg::ADDR_W-1:0] rd_addr;
  logic [fifo_cfg_pkg::DATA_W-1:0] mem_rd_data;
  fifo_types_pkg::fifo_status_t    status;

  // ======================================
  // pointer control
  // ======================================

  fifo_ptr u_ptr (
    .clk_i     ( clk_i    ),
    .srst_i    ( srst_i   ),

    .wr_en_i   ( wr_en_i  ),
    .rd_en_i   ( rd_en_i  ),

    .wr_addr_o ( wr_addr  ),
    .rd_addr_o ( rd_addr  ),
    .status_o  ( status   )
  );

  // ======================================
  // storage
  // ======================================

  fifo_mem u_mem (
    .clk_i     ( clk_i       ),

    .wr_en_i   ( wr_en_i     ),
    .wr_addr_i ( wr_addr     ),
    .wr_data_i ( wr_data_i   ),

    .rd_addr_i ( rd_addr     ),
    .rd_data_o ( mem_rd_data )
  );

  // ======================================
  // output word
  // ======================================

  // stale array contents stay hidden while empty.
  always_comb
  begin
    if (status.empty)
    begin
      rd_data_o = '0;
    end
    else
    begin
      rd_data_o = mem_rd_data;
    end
  end

  assign status_o = status;

endmodule : fifo

`default_nettype wire

// File: fifo/fifo_ptr.sv
`default_nettype none

module fifo_ptr (
  input  logic                              clk_i,
  input  logic                              srst_i,

  input  logic                              wr_en_i,
  input  logic                              rd_en_i,

  output logic [fifo_cfg_pkg::ADDR_W-1:0]   wr_addr_o,
  output logic [fifo_cfg_pkg::ADDR_W-1:0]   rd_addr_o,
  output fifo_types_pkg::fifo_status_t      status_o
);

  logic [fifo_cfg_pkg::ADDR_W-1:0] wr_ptr_r;
  logic [fifo_cfg_pkg::ADDR_W-1:0] rd_ptr_r;
  logic [fifo_cfg_pkg::CNT_W-1:0]  count_r;

  // ======================================
  // pointers
  // ======================================

  // DEPTH is a power of two, so the pointers wrap by overflow.
  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      wr_ptr_r <= '0;
    end
    else if (wr_en_i)
    begin
      wr_ptr_r <= wr_ptr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      rd_ptr_r <= '0;
    end
    else if (rd_en_i)
    begin
      rd_ptr_r <= rd_ptr_r + 1'b1;   // move past the head word.
    end
  end

  // ======================================
  // fill count
  // ======================================

  always_ff @(posedge clk_i)
  begin
    if (srst_i)
    begin
      count_r <= '0;
    end
    else
    begin
      case ({wr_en_i, rd_en_i})
        2'b10:   count_r <= count_r + 1'b1;   // lone write.
        2'b01:   count_r <= count_r - 1'b1;   // lone read.
        default: count_r <= count_r;          // idle or both.
      endcase
    end
  end

  // ======================================
  // addresses and flags
  // ======================================

  assign wr_addr_o = wr_ptr_r;
  assign rd_addr_o = rd_ptr_r;

  // all flags come from the registered count.
  always_comb
  begin
    status_o.usedw        = count_r;
    status_o.empty        = (count_r == '0);
    status_o.full         = (count_r == fifo_cfg_pkg::CNT_W'(fifo_cfg_pkg::DEPTH));
    status_o.almost_full  = (count_r >= fifo_cfg_pkg::CNT_W'(fifo_cfg_pkg::ALMOST_FULL_LVL));
    status_o.almost_empty = (count_r <= fifo_cfg_pkg::CNT_W'(fifo_cfg_pkg::ALMOST_EMPTY_LVL));
  end

endmodule : fifo_ptr

`default_nettype wire

// File: fifo/fifo_mem.sv
`default_nettype none

module fifo_mem (
  input  logic                              clk_i,

  input  logic                              wr_en_i,
  input  logic [fifo_cfg_pkg::ADDR_W-1:0]   wr_addr_i,
  input  logic [fifo_cfg_pkg::DATA_W-1:0]   wr_data_i,

  input  logic [fifo_cfg_pkg::ADDR_W-1:0]   rd_addr_i,
  output logic [fifo_cfg_pkg::DATA_W-1:0]   rd_data_o
);

  // ======================================
  // storage array
  // ======================================

  logic [fifo_cfg_pkg::DATA_W-1:0] mem_r [fifo_cfg_pkg::DEPTH];

  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
    begin
      mem_r[wr_addr_i] <= wr_data_i;   // write on the accepting edge.
    end
  end

  // ======================================
  // show-ahead read port
  // ======================================

  // head word is visible without a read strobe.
  always_comb
  begin
    rd_data_o = mem_r[rd_addr_i];
  end

endmodule : fifo_mem

`default_nettype wire

// File: common/fifo_types_pkg.sv
`default_nettype none

package fifo_types_pkg;

  // ======================================
  // fifo status word
  // ======================================

  // usedw sits in the upper bits, flags below.
  typedef struct packed {
    logic [fifo_cfg_pkg::CNT_W-1:0] usedw;         // current fill level.
    logic                           empty;         // no words stored.
    logic                           full;          // DEPTH words stored.
    logic                           almost_full;   // level at or above threshold.
    logic                           almost_empty;  // level at or below threshold.
  } fifo_status_t;

  // ======================================
  // guard error counters
  // ======================================

  typedef struct packed {
    logic [fifo_cfg_pkg::ERR_CNT_W-1:0] ovf_cnt;   // writes dropped at full.
    logic [fifo_cfg_pkg::ERR_CNT_W-1:0] unf_cnt;   // reads dropped at empty.
  } fifo_err_t;

endpackage : fifo_types_pkg

`default_nettype wire

// File: common/fifo_cfg_pkg.sv
`default_nettype none

package fifo_cfg_pkg;

  // ======================================
  // storage geometry
  // ======================================

  localparam int DATA_W = 8;             // sample word width.

  localparam int ADDR_W = 3;             // storage address width.

  localparam int DEPTH = 2 ** ADDR_W;    // entries in the array.

  localparam int CNT_W = ADDR_W + 1;     // holds 0 to DEPTH.

  // ======================================
  // flag thresholds and error counters
  // ======================================

  localparam int ALMOST_FULL_LVL = 6;    // set at or above.

  localparam int ALMOST_EMPTY_LVL = 2;   // set at or below.

  localparam int ERR_CNT_W = 8;          // saturating reject counters.

endpackage : fifo_cfg_pkg

`default_nettype wire
